// ==== filelist.f ====
rtl/icache_pkg.sv
rtl/icache_tag_check.sv
rtl/icache_way_repl.sv
rtl/icache_bypass_path.sv
rtl/icache_ctrl_fsm.sv
rtl/icache_ctrl_top.sv
tb/tb_icache_mem.sv
tb/tb_icache_ctrl.sv

// ==== Bender.yml ====
package:
  name: icache_ctrl

sources:
  - rtl/icache_pkg.sv
  - rtl/icache_tag_check.sv
  - rtl/icache_way_repl.sv
  - rtl/icache_bypass_path.sv
  - rtl/icache_ctrl_fsm.sv
  - rtl/icache_ctrl_top.sv
  - target: simulation
    files:
      - tb/tb_icache_mem.sv
      - tb/tb_icache_ctrl.sv

// ==== tb/tb_icache_ctrl.sv ====
/*
 * Instruction cache controller testbench
 * Bypass, flush on enable, miss and hit, way fill, set flush
 */
`timescale 1ns/10ps

module tb_icache_ctrl;
   import icache_pkg::*;

   localparam int L2_MAX_DELAY = 7;
   localparam int NB_FETCHES   = 30;
   localparam int WATCHDOG_CYCLES = NB_FETCHES * (2 * (L2_MAX_DELAY + 1) + 6) + NB_SETS + 40;

   logic        clk;
   logic        rst_n;
   logic        bypass_icache;
   logic        flush_icache;
   logic        flush_set_id_req;
   fetch_addr_t flush_set_id_addr;
   logic        cache_is_bypassed;
   logic        cache_is_flushed;
   logic        flush_set_id_ack;
   logic        fetch_req;
   fetch_addr_t fetch_addr;
   logic        fetch_gnt;
   logic        fetch_rvalid;
   fetch_data_t fetch_rdata;
   way_oh_t     tag_req;
   logic        tag_we;
   set_idx_t    tag_addr;
   tag_entry_t  tag_wdata;
   way_tags_t   tag_rdata;
   way_oh_t     data_req;
   logic        data_we;
   set_idx_t    data_addr;
   fetch_data_t data_wdata;
   way_data_t   data_rdata;
   logic        refill_req;
   logic        refill_gnt;
   fetch_addr_t refill_addr;
   logic        refill_r_valid;
   fetch_data_t refill_r_data;

   // Phase flags that enable the timing checks
   logic        byp_phase;
   logic        miss_phase;
   logic        hit_phase;

   int          errors;
   int          checks;
   string       test_name;
   fetch_addr_t exp_q[$];

   icache_ctrl_top u_icache_ctrl_top (
      .clk                 (clk),
      .rst_n               (rst_n),
      .bypass_icache_i     (bypass_icache),
      .flush_icache_i      (flush_icache),
      .flush_set_id_req_i  (flush_set_id_req),
      .flush_set_id_addr_i (flush_set_id_addr),
      .cache_is_bypassed_o (cache_is_bypassed),
      .cache_is_flushed_o  (cache_is_flushed),
      .flush_set_id_ack_o  (flush_set_id_ack),
      .fetch_req_i         (fetch_req),
      .fetch_addr_i        (fetch_addr),
      .fetch_gnt_o         (fetch_gnt),
      .fetch_rvalid_o      (fetch_rvalid),
      .fetch_rdata_o       (fetch_rdata),
      .tag_req_o           (tag_req),
      .tag_we_o            (tag_we),
      .tag_addr_o          (tag_addr),
      .tag_wdata_o         (tag_wdata),
      .tag_rdata_i         (tag_rdata),
      .data_req_o          (data_req),
      .data_we_o           (data_we),
      .data_addr_o         (data_addr),
      .data_wdata_o        (data_wdata),
      .data_rdata_i        (data_rdata),
      .refill_req_o        (refill_req),
      .refill_gnt_i        (refill_gnt),
      .refill_addr_o       (refill_addr),
      .refill_r_valid_i    (refill_r_valid),
      .refill_r_data_i     (refill_r_data)
   );

   tb_icache_mem #(
      .MAX_DELAY (L2_MAX_DELAY),
      .SEED      (32'h29a2_f48e)
   ) u_mem (
      .clk              (clk),
      .rst_n            (rst_n),
      .tag_req_i        (tag_req),
      .tag_we_i         (tag_we),
      .tag_addr_i       (tag_addr),
      .tag_wdata_i      (tag_wdata),
      .tag_rdata_o      (tag_rdata),
      .data_req_i       (data_req),
      .data_we_i        (data_we),
      .data_addr_i      (data_addr),
      .data_wdata_i     (data_wdata),
      .data_rdata_o     (data_rdata),
      .refill_req_i     (refill_req),
      .refill_addr_i    (refill_addr),
      .refill_gnt_o     (refill_gnt),
      .refill_r_valid_o (refill_r_valid),
      .refill_r_data_o  (refill_r_data)
   );

   always #5 clk = ~clk;

   // Expected L2 word for a line
   function automatic fetch_data_t line_word(input fetch_addr_t a);
      logic [31:0] line;
      line = {a[31:4], 4'h0};
      return {line ^ 32'hdead_beef, ~line, line + 32'h1357_9bdf, {line[15:0], line[31:16]}};
   endfunction

   function automatic fetch_addr_t make_addr(input int tag, input int set);
      return fetch_addr_t'((tag << TAG_LSB) | (set << LINE_OFFSET_W));
   endfunction

   task automatic report_failure(input string what);
      errors++;
      $display("%s: %s", test_name, what);
   endtask

   //////////////////////////////
   // Checks
   //////////////////////////////
   assert property (@(posedge clk) disable iff (!rst_n)
      byp_phase |-> cache_is_bypassed && cache_is_flushed && flush_set_id_ack)
      else report_failure("cache left bypass mode");
   assert property (@(posedge clk) disable iff (!rst_n) byp_phase && fetch_req |-> fetch_gnt)
      else report_failure("bypass fetch not granted at once");
   assert property (@(posedge clk) disable iff (!rst_n)
      $fell(cache_is_bypassed) |-> (!fetch_gnt && !cache_is_flushed) [*NB_SETS-1]
      ##1 (cache_is_flushed && !fetch_gnt) ##1 !cache_is_flushed)
      else report_failure("full flush timing is wrong");
   assert property (@(posedge clk) disable iff (!rst_n)
      miss_phase && fetch_req && fetch_gnt |=> refill_req)
      else report_failure("miss raised no refill request");
   assert property (@(posedge clk) disable iff (!rst_n) hit_phase |-> !refill_req)
      else report_failure("refill request on a hit");
   assert property (@(posedge clk) disable iff (!rst_n)
      hit_phase |-> !cache_is_bypassed && !cache_is_flushed && !flush_set_id_ack)
      else report_failure("bypass or flush status raised while serving hits");
   assert property (@(posedge clk) disable iff (!rst_n)
      hit_phase && fetch_req && fetch_gnt |=> fetch_rvalid)
      else report_failure("hit response not one cycle after grant");
   assert property (@(posedge clk) disable iff (!rst_n) hit_phase && fetch_req |-> fetch_gnt)
      else report_failure("hits do not stream");

   // Responses in order against accepted addresses
   always @(negedge clk)
   begin
      fetch_data_t exp;
      if (rst_n)
      begin
         if (fetch_req && fetch_gnt)
            exp_q.push_back(fetch_addr);
         if (fetch_rvalid)
         begin
            if (exp_q.size() == 0)
               report_failure("response without an accepted request");
            else
            begin
               exp = line_word(exp_q.pop_front());
               checks++;
               assert (fetch_rdata == exp)
               else
               begin
                  errors++;
                  $display("error %s: expected %h actual %h", test_name, exp, fetch_rdata);
               end
            end
         end
      end
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////
   // Mode 1 expects misses, mode 2 expects streaming hits
   task automatic run_fetches(input fetch_addr_t a, input int n, input int mode);
      int granted;
      granted = 0;
      @(posedge clk);
      fetch_req  <= 1'b1;
      fetch_addr <= a;
      miss_phase <= (mode == 1);
      hit_phase  <= (mode == 2);
      while (granted < n)
      begin
         @(negedge clk);
         if (fetch_gnt)
            granted++;
      end
      @(posedge clk);
      fetch_req <= 1'b0;
      while (exp_q.size() != 0)
         @(posedge clk);
      miss_phase <= 1'b0;
      hit_phase  <= 1'b0;
   endtask

   task automatic flush_one_set(input fetch_addr_t a);
      @(posedge clk);
      flush_set_id_req  <= 1'b1;
      flush_set_id_addr <= a;
      do
         @(negedge clk);
      while (!flush_set_id_ack);
      @(posedge clk);
      flush_set_id_req <= 1'b0;
   endtask

   initial
   begin
      clk               = 1'b0;
      rst_n             = 1'b0;
      bypass_icache     = 1'b1;
      flush_icache      = 1'b0;
      flush_set_id_req  = 1'b0;
      flush_set_id_addr = '0;
      fetch_req         = 1'b0;
      fetch_addr        = '0;
      byp_phase         = 1'b0;
      miss_phase        = 1'b0;
      hit_phase         = 1'b0;
      errors            = 0;
      checks            = 0;
      test_name         = "reset";
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      test_name = "bypass";
      @(posedge clk);
      byp_phase <= 1'b1;
      for (int i = 0; i < 4; i++)
         run_fetches(make_addr(i + 3, i), 1, 0);

      test_name = "flush_on_enable";
      @(posedge clk);
      byp_phase     <= 1'b0;
      bypass_icache <= 1'b0;
      run_fetches(make_addr(1, 2), 1, 1);

      test_name = "miss_then_hit";
      run_fetches(make_addr(5, 1), 1, 1);
      run_fetches(make_addr(5, 1), 1, 2);
      run_fetches(make_addr(5, 1), 4, 2);

      test_name = "free_ways";
      for (int t = 10; t < 10 + NB_WAYS; t++)
         run_fetches(make_addr(t, 6), 1, 1);
      for (int t = 10; t < 10 + NB_WAYS; t++)
         run_fetches(make_addr(t, 6), 2, 2);
      run_fetches(make_addr(14, 6), 1, 1);

      test_name = "set_flush";
      flush_one_set(make_addr(0, 6));
      run_fetches(make_addr(14, 6), 1, 1);
      run_fetches(make_addr(5, 1), 1, 2);

      repeat (2) @(posedge clk);
      $display("errors: %0d, data checks: %0d", errors, checks);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// ==== tb/tb_icache_mem.sv ====
/*
 * Behavioral per-way tag and data SCM arrays with one-cycle reads
 * Single-beat L2 model with xorshift-random grant and return delays
 */
`timescale 1ns/10ps

module tb_icache_mem #(
   parameter int          MAX_DELAY = 7,
   parameter logic [31:0] SEED      = 32'h29a2_f48e
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  icache_pkg::way_oh_t      tag_req_i,
   input  logic                     tag_we_i,
   input  icache_pkg::set_idx_t     tag_addr_i,
   input  icache_pkg::tag_entry_t   tag_wdata_i,
   output icache_pkg::way_tags_t    tag_rdata_o,
   input  icache_pkg::way_oh_t      data_req_i,
   input  logic                     data_we_i,
   input  icache_pkg::set_idx_t     data_addr_i,
   input  icache_pkg::fetch_data_t  data_wdata_i,
   output icache_pkg::way_data_t    data_rdata_o,
   input  logic                     refill_req_i,
   input  icache_pkg::fetch_addr_t  refill_addr_i,
   output logic                     refill_gnt_o,
   output logic                     refill_r_valid_o,
   output icache_pkg::fetch_data_t  refill_r_data_o
);
   import icache_pkg::*;

   tag_entry_t  tag_mem  [NB_WAYS][NB_SETS];
   fetch_data_t data_mem [NB_WAYS][NB_SETS];

   logic [31:0] rng_q;
   int          wait_cnt_q;
   int          ret_cnt_q;
   logic        busy_q;
   fetch_addr_t l2_addr_q;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Fixed mix of the line address
   function automatic fetch_data_t line_word(input fetch_addr_t a);
      logic [31:0] line;
      line = {a[31:4], 4'h0};
      return {line ^ 32'hdead_beef, ~line, line + 32'h1357_9bdf, {line[15:0], line[31:16]}};
   endfunction

   //////////////////////////////
   // SCM arrays
   //////////////////////////////
   always_ff @(posedge clk)
   begin
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (tag_req_i[w])
         begin
            if (tag_we_i)
               tag_mem[w][tag_addr_i] <= tag_wdata_i;
            else
               tag_rdata_o[w] <= tag_mem[w][tag_addr_i];
         end
         if (data_req_i[w])
         begin
            if (data_we_i)
               data_mem[w][data_addr_i] <= data_wdata_i;
            else
               data_rdata_o[w] <= data_mem[w][data_addr_i];
         end
      end
   end

   //////////////////////////////
   // L2 model
   //////////////////////////////
   // One request in flight, grant only when idle and the wait has run out
   assign refill_gnt_o = refill_req_i && !busy_q && (wait_cnt_q == 0);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rng_q            <= SEED;
         wait_cnt_q       <= 0;
         ret_cnt_q        <= 0;
         busy_q           <= 1'b0;
         l2_addr_q        <= '0;
         refill_r_valid_o <= 1'b0;
         refill_r_data_o  <= '0;
      end
      else
      begin
         refill_r_valid_o <= 1'b0;
         if (refill_gnt_o)
         begin
            busy_q    <= 1'b1;
            l2_addr_q <= refill_addr_i;
            ret_cnt_q <= int'(rng_q % (MAX_DELAY + 1));
            rng_q     <= xorshift(rng_q);
         end
         else if (refill_req_i && !busy_q && wait_cnt_q != 0)
            wait_cnt_q <= wait_cnt_q - 1;

         if (busy_q)
         begin
            if (ret_cnt_q == 0)
            begin
               refill_r_valid_o <= 1'b1;
               refill_r_data_o  <= line_word(l2_addr_q);
               busy_q           <= 1'b0;
               wait_cnt_q       <= int'(rng_q % (MAX_DELAY + 1));
               rng_q            <= xorshift(rng_q);
            end
            else
               ret_cnt_q <= ret_cnt_q - 1;
         end
      end
   end

endmodule

// ==== rtl/icache_ctrl_top.sv ====
/*
 * Instruction cache controller top level
 * Connects FSM, tag check, way replacement and bypass path
 */
`timescale 1ns/10ps

module icache_ctrl_top (
   input  logic                     clk,
   input  logic                     rst_n,

   input  logic                     bypass_icache_i,
   input  logic                     flush_icache_i,
   input  logic                     flush_set_id_req_i,
   input  icache_pkg::fetch_addr_t  flush_set_id_addr_i,
   output logic                     cache_is_bypassed_o,
   output logic                     cache_is_flushed_o,
   output logic                     flush_set_id_ack_o,

   input  logic                     fetch_req_i,
   input  icache_pkg::fetch_addr_t  fetch_addr_i,
   output logic                     fetch_gnt_o,
   output logic                     fetch_rvalid_o,
   output icache_pkg::fetch_data_t  fetch_rdata_o,

   output icache_pkg::way_oh_t      tag_req_o,
   output logic                     tag_we_o,
   output icache_pkg::set_idx_t     tag_addr_o,
   output icache_pkg::tag_entry_t   tag_wdata_o,
   input  icache_pkg::way_tags_t    tag_rdata_i,

   output icache_pkg::way_oh_t      data_req_o,
   output logic                     data_we_o,
   output icache_pkg::set_idx_t     data_addr_o,
   output icache_pkg::fetch_data_t  data_wdata_o,
   input  icache_pkg::way_data_t    data_rdata_i,

   output logic                     refill_req_o,
   input  logic                     refill_gnt_i,
   output icache_pkg::fetch_addr_t  refill_addr_o,
   input  logic                     refill_r_valid_i,
   input  icache_pkg::fetch_data_t  refill_r_data_i
);
   import icache_pkg::*;

   logic        byp_req;
   fetch_addr_t byp_addr;
   logic        byp_pending;

   way_oh_t     way_hit;
   logic        all_valid;
   way_idx_t    hit_way;
   way_idx_t    first_free_way;

   way_oh_t     refill_way;
   logic        save_way;
   tag_t        lookup_tag;

   icache_ctrl_fsm u_fsm (
      .clk                 (clk),
      .rst_n               (rst_n),
      .bypass_icache_i     (bypass_icache_i),
      .flush_icache_i      (flush_icache_i),
      .flush_set_id_req_i  (flush_set_id_req_i),
      .flush_set_id_addr_i (flush_set_id_addr_i),
      .cache_is_bypassed_o (cache_is_bypassed_o),
      .cache_is_flushed_o  (cache_is_flushed_o),
      .flush_set_id_ack_o  (flush_set_id_ack_o),
      .fetch_req_i         (fetch_req_i),
      .fetch_addr_i        (fetch_addr_i),
      .fetch_gnt_o         (fetch_gnt_o),
      .fetch_rvalid_o      (fetch_rvalid_o),
      .fetch_rdata_o       (fetch_rdata_o),
      .tag_req_o           (tag_req_o),
      .tag_we_o            (tag_we_o),
      .tag_addr_o          (tag_addr_o),
      .tag_wdata_o         (tag_wdata_o),
      .data_req_o          (data_req_o),
      .data_we_o           (data_we_o),
      .data_addr_o         (data_addr_o),
      .data_wdata_o        (data_wdata_o),
      .data_rdata_i        (data_rdata_i),
      .refill_req_o        (refill_req_o),
      .refill_gnt_i        (refill_gnt_i),
      .refill_addr_o       (refill_addr_o),
      .refill_r_valid_i    (refill_r_valid_i),
      .refill_r_data_i     (refill_r_data_i),
      .byp_req_i           (byp_req),
      .byp_addr_i          (byp_addr),
      .byp_pending_i       (byp_pending),
      .way_hit_i           (way_hit),
      .hit_way_i           (hit_way),
      .refill_way_i        (refill_way),
      .save_way_o          (save_way),
      .lookup_tag_o        (lookup_tag)
   );

   icache_tag_check u_tag_check (
      .tag_rdata_i      (tag_rdata_i),
      .lookup_tag_i     (lookup_tag),
      .way_hit_o        (way_hit),
      .all_valid_o      (all_valid),
      .hit_way_o        (hit_way),
      .first_free_way_o (first_free_way)
   );

   icache_way_repl u_way_repl (
      .clk              (clk),
      .rst_n            (rst_n),
      .save_way_i       (save_way),
      .all_valid_i      (all_valid),
      .first_free_way_i (first_free_way),
      .refill_way_o     (refill_way)
   );

   icache_bypass_path u_bypass_path (
      .clk              (clk),
      .rst_n            (rst_n),
      .bypass_icache_i  (bypass_icache_i),
      .fetch_req_i      (fetch_req_i),
      .fetch_gnt_i      (fetch_gnt_o),
      .fetch_addr_i     (fetch_addr_i),
      .refill_gnt_i     (refill_gnt_i),
      .refill_r_valid_i (refill_r_valid_i),
      .byp_req_o        (byp_req),
      .byp_addr_o       (byp_addr),
      .byp_pending_o    (byp_pending)
   );

endmodule

// ==== rtl/icache_ctrl_fsm.sv ====
/*
 * Instruction cache control FSM
 * State, flush counter and fetch pipeline registers
 * SCM access, fetch grant and response, refill request
 */
`timescale 1ns/10ps

module icache_ctrl_fsm (
   input  logic                     clk,
   input  logic                     rst_n,

   input  logic                     bypass_icache_i,
   input  logic                     flush_icache_i,
   input  logic                     flush_set_id_req_i,
   input  icache_pkg::fetch_addr_t  flush_set_id_addr_i,
   output logic                     cache_is_bypassed_o,
   output logic                     cache_is_flushed_o,
   output logic                     flush_set_id_ack_o,

   input  logic                     fetch_req_i,
   input  icache_pkg::fetch_addr_t  fetch_addr_i,
   output logic                     fetch_gnt_o,
   output logic                     fetch_rvalid_o,
   output icache_pkg::fetch_data_t  fetch_rdata_o,

   output icache_pkg::way_oh_t      tag_req_o,
   output logic                     tag_we_o,
   output icache_pkg::set_idx_t     tag_addr_o,
   output icache_pkg::tag_entry_t   tag_wdata_o,

   output icache_pkg::way_oh_t      data_req_o,
   output logic                     data_we_o,
   output icache_pkg::set_idx_t     data_addr_o,
   output icache_pkg::fetch_data_t  data_wdata_o,
   input  icache_pkg::way_data_t    data_rdata_i,

   output logic                     refill_req_o,
   input  logic                     refill_gnt_i,
   output icache_pkg::fetch_addr_t  refill_addr_o,
   input  logic                     refill_r_valid_i,
   input  icache_pkg::fetch_data_t  refill_r_data_i,

   input  logic                     byp_req_i,
   input  icache_pkg::fetch_addr_t  byp_addr_i,
   input  logic                     byp_pending_i,

   input  icache_pkg::way_oh_t      way_hit_i,
   input  icache_pkg::way_idx_t     hit_way_i,
   input  icache_pkg::way_oh_t      refill_way_i,
   output logic                     save_way_o,
   output icache_pkg::tag_t         lookup_tag_o
);
   import icache_pkg::*;

   icache_state_e state_q;
   icache_state_e state_d;
   icache_state_e cmd_state;
   logic          cmd_req;
   set_idx_t      flush_cnt_q;
   set_idx_t      flush_cnt_d;
   fetch_addr_t   fetch_addr_q;
   logic          fetch_req_q;
   logic          fetch_req_d;
   logic          pipe_en;
   set_idx_t      fetch_set;
   set_idx_t      lookup_set;

   assign fetch_set    = fetch_addr_i[LINE_OFFSET_W +: SET_IDX_W];
   assign lookup_set   = fetch_addr_q[LINE_OFFSET_W +: SET_IDX_W];
   assign lookup_tag_o = fetch_addr_q[TAG_LSB +: TAG_W];

   // Command priority: bypass, full flush, set flush
   assign cmd_req = bypass_icache_i | flush_icache_i | flush_set_id_req_i;

   always_comb
   begin
      if (bypass_icache_i)
         cmd_state = ST_BYPASS;
      else if (flush_icache_i)
         cmd_state = ST_FLUSH_ALL;
      else
         cmd_state = ST_FLUSH_SET;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q     <= ST_BYPASS;
         flush_cnt_q <= '0;
         fetch_req_q <= 1'b0;
      end
      else
      begin
         state_q     <= state_d;
         flush_cnt_q <= flush_cnt_d;
         fetch_req_q <= fetch_req_d;
      end
   end

   always_ff @(posedge clk)
   begin
      if (pipe_en)
         fetch_addr_q <= fetch_addr_i;
   end

   always_comb
   begin
      state_d             = state_q;
      flush_cnt_d         = flush_cnt_q;
      fetch_req_d         = fetch_req_q;
      pipe_en             = 1'b0;
      save_way_o          = 1'b0;

      cache_is_bypassed_o = 1'b0;
      cache_is_flushed_o  = 1'b0;
      flush_set_id_ack_o  = 1'b0;

      fetch_gnt_o         = 1'b0;
      fetch_rvalid_o      = 1'b0;
      fetch_rdata_o       = refill_r_data_i;

      tag_req_o           = '0;
      tag_we_o            = 1'b0;
      tag_addr_o          = fetch_set;
      tag_wdata_o         = {1'b1, lookup_tag_o};
      data_req_o          = '0;
      data_we_o           = 1'b0;
      data_addr_o         = fetch_set;
      data_wdata_o        = refill_r_data_i;

      refill_req_o        = 1'b0;
      refill_addr_o       = fetch_addr_q;

      case (state_q)
         ST_BYPASS:
         begin
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            flush_set_id_ack_o  = 1'b1;
            fetch_rvalid_o      = refill_r_valid_i;
            fetch_req_d         = 1'b0;
            flush_cnt_d         = '0;
            if (bypass_icache_i || byp_pending_i)
            begin
               // Single L2 beat in flight, next fetch taken as the beat returns
               fetch_gnt_o   = fetch_req_i & bypass_icache_i &
                               (~byp_pending_i | refill_r_valid_i);
               refill_req_o  = byp_req_i;
               refill_addr_o = byp_addr_i;
            end
            else
               state_d = ST_FLUSH_ALL;
         end

         ST_FLUSH_ALL:
         begin
            flush_set_id_ack_o = 1'b1;
            tag_req_o          = '1;
            tag_we_o           = 1'b1;
            tag_addr_o         = flush_cnt_q;
            tag_wdata_o        = '0;
            if (flush_cnt_q == set_idx_t'(NB_SETS - 1))
            begin
               cache_is_flushed_o = 1'b1;
               flush_cnt_d        = '0;
               state_d            = ST_IDLE;
            end
            else
               flush_cnt_d = flush_cnt_q + 1'b1;
         end

         ST_FLUSH_SET:
         begin
            flush_set_id_ack_o = 1'b1;
            tag_req_o          = '1;
            tag_we_o           = 1'b1;
            tag_addr_o         = flush_set_id_addr_i[LINE_OFFSET_W +: SET_IDX_W];
            tag_wdata_o        = '0;
            state_d            = ST_IDLE;
         end

         ST_IDLE, ST_LOOKUP:
         begin
            if (fetch_req_q && !(|way_hit_i))
            begin
               // Miss: hold the refill and re-read the tags of the same set
               refill_req_o = 1'b1;
               save_way_o   = refill_gnt_i;
               tag_req_o    = '1;
               tag_addr_o   = lookup_set;
               if (refill_gnt_i)
                  state_d = ST_REFILL;
            end
            else
            begin
               if (fetch_req_q)
               begin
                  fetch_rvalid_o = 1'b1;
                  fetch_rdata_o  = data_rdata_i[hit_way_i];
               end
               fetch_gnt_o = fetch_req_i & ~cmd_req;
               fetch_req_d = fetch_gnt_o;
               pipe_en     = fetch_gnt_o;
               tag_req_o   = {NB_WAYS{fetch_gnt_o}};
               data_req_o  = {NB_WAYS{fetch_gnt_o}};
               if (fetch_gnt_o)
                  state_d = ST_LOOKUP;
               else if (cmd_req && !fetch_req_q)
                  state_d = cmd_state;
               else
                  state_d = ST_IDLE;
            end
         end

         ST_REFILL:
         begin
            fetch_rvalid_o = refill_r_valid_i;
            tag_req_o      = refill_way_i & {NB_WAYS{refill_r_valid_i}};
            tag_we_o       = 1'b1;
            tag_addr_o     = lookup_set;
            data_req_o     = refill_way_i & {NB_WAYS{refill_r_valid_i}};
            data_we_o      = 1'b1;
            data_addr_o    = lookup_set;
            if (refill_r_valid_i)
            begin
               fetch_req_d = 1'b0;
               state_d     = ST_IDLE;
            end
         end

         default:
            state_d = ST_BYPASS;
      endcase
   end

endmodule

// ==== rtl/icache_bypass_path.sv ====
/*
 * Bypass fetch path
 * One-cycle delayed refill request and address, outstanding beat flag
 */
`timescale 1ns/10ps

module icache_bypass_path (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     bypass_icache_i,
   input  logic                     fetch_req_i,
   input  logic                     fetch_gnt_i,
   input  icache_pkg::fetch_addr_t  fetch_addr_i,
   input  logic                     refill_gnt_i,
   input  logic                     refill_r_valid_i,
   output logic                     byp_req_o,
   output icache_pkg::fetch_addr_t  byp_addr_o,
   output logic                     byp_pending_o
);
   import icache_pkg::*;

   logic        byp_accept;
   logic        byp_req_q;
   logic        byp_pending_q;
   fetch_addr_t byp_addr_q;

   // Fetch accepted while the cache is bypassed
   assign byp_accept = fetch_req_i & fetch_gnt_i & bypass_icache_i;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         byp_req_q     <= 1'b0;
         byp_pending_q <= 1'b0;
      end
      else
      begin
         // Held until L2 grants it
         if (byp_accept)
            byp_req_q <= 1'b1;
         else if (refill_gnt_i)
            byp_req_q <= 1'b0;

         // Cleared by the returning beat so the cache waits for it
         if (byp_accept)
            byp_pending_q <= 1'b1;
         else if (refill_r_valid_i)
            byp_pending_q <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (byp_accept)
         byp_addr_q <= fetch_addr_i;
   end

   assign byp_req_o     = byp_req_q;
   assign byp_addr_o    = byp_addr_q;
   assign byp_pending_o = byp_pending_q;

endmodule

// ==== rtl/icache_way_repl.sv ====
/*
 * Refill way selection
 * LFSR victim when the set is full, else the first free way
 */
`timescale 1ns/10ps

module icache_way_repl (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  save_way_i,
   input  logic                  all_valid_i,
   input  icache_pkg::way_idx_t  first_free_way_i,
   output icache_pkg::way_oh_t   refill_way_o
);
   import icache_pkg::*;

   logic [LFSR_W-1:0] lfsr_q;
   logic              lfsr_fb;
   way_idx_t          victim_way;
   way_oh_t           refill_way_q;

   // Taps for x^8 + x^6 + x^5 + x^4 + 1
   assign lfsr_fb    = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
   assign victim_way = all_valid_i ? lfsr_q[WAY_IDX_W-1:0] : first_free_way_i;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         lfsr_q       <= LFSR_SEED;
         refill_way_q <= '0;
      end
      else if (save_way_i)
      begin
         refill_way_q <= way_oh_t'(1) << victim_way;
         // Only an eviction consumes a random value
         if (all_valid_i)
            lfsr_q <= {lfsr_q[LFSR_W-2:0], lfsr_fb};
      end
   end

   assign refill_way_o = refill_way_q;

endmodule

// ==== rtl/icache_tag_check.sv ====
/*
 * Per-way tag compare
 * Hit mask, hit way and first free way encoders
 */
`timescale 1ns/10ps

module icache_tag_check (
   input  icache_pkg::way_tags_t tag_rdata_i,
   input  icache_pkg::tag_t      lookup_tag_i,
   output icache_pkg::way_oh_t   way_hit_o,
   output logic                  all_valid_o,
   output icache_pkg::way_idx_t  hit_way_o,
   output icache_pkg::way_idx_t  first_free_way_o
);
   import icache_pkg::*;

   way_oh_t way_valid;

   always_comb
   begin
      for (int w = 0; w < NB_WAYS; w++)
      begin
         way_valid[w] = tag_rdata_i[w][TAG_W];
         way_hit_o[w] = way_valid[w] && (tag_rdata_i[w][TAG_W-1:0] == lookup_tag_i);
      end
   end

   assign all_valid_o = &way_valid;

   // Highest index wins in both encoders
   always_comb
   begin
      hit_way_o        = '0;
      first_free_way_o = '0;
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (way_hit_o[w])
            hit_way_o = way_idx_t'(w);
         if (!way_valid[w])
            first_free_way_o = way_idx_t'(w);
      end
   end

endmodule

// ==== rtl/icache_pkg.sv ====
/*
 * Shared instruction cache definitions
 * Address split, widths and replacement seed
 * Vector typedefs and the controller state enum
 */
package icache_pkg;

   //////////////////////////////
   // Widths and geometry
   //////////////////////////////
   localparam int FETCH_ADDR_W  = 32;
   localparam int FETCH_DATA_W  = 128;
   localparam int NB_WAYS       = 4;
   localparam int WAY_IDX_W     = $clog2(NB_WAYS);

   // One 128-bit word per line, set index right above the byte offset
   localparam int LINE_OFFSET_W = 4;
   localparam int SET_IDX_W     = 4;
   localparam int NB_SETS       = 1 << SET_IDX_W;
   localparam int TAG_W         = 7;
   localparam int TAG_LSB       = LINE_OFFSET_W + SET_IDX_W;

   // Victim selection LFSR
   localparam int                LFSR_W    = 8;
   localparam logic [LFSR_W-1:0] LFSR_SEED = 8'hA5;

   //////////////////////////////
   // Types
   //////////////////////////////
   typedef logic [FETCH_ADDR_W-1:0] fetch_addr_t;
   typedef logic [FETCH_DATA_W-1:0] fetch_data_t;
   typedef logic [SET_IDX_W-1:0]    set_idx_t;
   typedef logic [TAG_W-1:0]        tag_t;
   // Valid bit on top of the stored tag
   typedef logic [TAG_W:0]          tag_entry_t;
   typedef logic [NB_WAYS-1:0]      way_oh_t;
   typedef logic [WAY_IDX_W-1:0]    way_idx_t;

   typedef tag_entry_t  [NB_WAYS-1:0] way_tags_t;
   typedef fetch_data_t [NB_WAYS-1:0] way_data_t;

   typedef enum logic [2:0] {
      ST_BYPASS,
      ST_FLUSH_ALL,
      ST_FLUSH_SET,
      ST_IDLE,
      ST_LOOKUP,
      ST_REFILL
   } icache_state_e;

endpackage
